// File: adc_acq_top.f
+incdir+common
common/acq_types_pkg.sv
common/acq_ctrl_pkg.sv
logic/acq_enable_fsm.sv
logic/sample_source.sv
circ_buf/circ_buf_ram.sv
circ_buf/trig_addr_fifo.sv
readout/readout_timer.sv
readout/waveform_readout.sv
logic/adc_acq_top.sv
sim/adc_acq_assert.sv
sim/adc_acq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the acquisition testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module adc_acq_tb -f adc_acq_top.f -o adc_acq_sim \
  && ./obj_dir/adc_acq_sim +verilator+error+limit+1000 \
     | tee /dev/stderr | grep -q "No errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/adc_acq_tb.sv
`timescale 1ns/1ps

module adc_acq_tb
  import acq_types_pkg::*;
  import acq_ctrl_pkg::*;
();

  logic        adc_clk;
  logic        arst_n;
  sample_t     adc_sample;
  logic        ext_enable;
  logic        ext_trig;
  acq_cfg_t    cfg;
  logic [23:0] initial_fill_num;
  logic        initial_fill_num_wr;
  acq_word_t   out_word;
  logic        out_valid;
  logic [23:0] fill_num;
  logic [15:0] waveform_num;
  logic        acq_idle;
  logic        ext_done;

  logic [31:0] lfsr_q;     // random state, one step per bit
  int          timeouts;
  int          hdr_cnt;    // header words seen
  int          tests_run;

  adc_acq_top i_dut (.*);

  always #4 adc_clk = ~adc_clk;  // 8 ns period

  always @(posedge adc_clk) begin
    if (out_valid && out_word.tag == TAG_HDR) hdr_cnt++;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  task automatic pulse_trigger();
    @(posedge adc_clk) ext_trig <= 1'b1;
    @(posedge adc_clk) ext_trig <= 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int i;
    i = 0;
    @(negedge adc_clk);
    while (!ext_done && i < limit) begin  // sampled away from the drive edge
      @(negedge adc_clk);
      i++;
    end
    if (!ext_done) begin
      timeouts++;
      $display("timeout: ext_done did not arrive within %0d cycles", limit);
    end
  endtask

  // one fill with random trigger spacing, wide enough to keep windows apart
  task automatic run_fill(input logic [11:0] tag, input int n_trig);
    int gap;
    @(posedge adc_clk) begin
      cfg        <= '{channel_tag: tag, num_words: 10'd4, pre_trig: 12'd8};
      ext_enable <= 1'b1;
    end
    tick(4100);  // whole buffer written before the first trigger
    for (int t = 0; t < n_trig; t++) begin
      pulse_trigger();
      draw_bits(6, gap);
      tick(60 + gap);
    end
    @(posedge adc_clk) ext_enable <= 1'b0;
    wait_done(20000);
  endtask

  task automatic report(input string name, input int err_before);
    int err_now;
    err_now = timeouts + i_dut.i_assert.fail_cnt;
    tests_run++;
    $display("test %0d %s: %s, headers %0d", tests_run, name,
             (err_now == err_before) ? "ok" : "failed", hdr_cnt);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int errs;
    adc_clk             = 1'b0;
    arst_n              = 1'b0;
    adc_sample          = '0;
    ext_enable          = 1'b0;
    ext_trig            = 1'b0;
    cfg                 = '{channel_tag: 12'h5a8, num_words: 10'd4, pre_trig: 12'd8};
    initial_fill_num    = '0;
    initial_fill_num_wr = 1'b0;
    lfsr_q              = 32'hb237;
    timeouts            = 0;
    hdr_cnt             = 0;
    tests_run           = 0;

    tick(5);  // reset held, idle outputs checked meanwhile
    @(posedge adc_clk) arst_n <= 1'b1;
    tick(2);
    report("reset state", 0);

    errs = timeouts + i_dut.i_assert.fail_cnt;
    @(posedge adc_clk) begin
      initial_fill_num    <= 24'h00a5c3;
      initial_fill_num_wr <= 1'b1;
    end
    @(posedge adc_clk) initial_fill_num_wr <= 1'b0;
    hdr_cnt = 0;
    run_fill(12'h5a8, 3);  // dummy data, free-running counter
    report("fill one, dummy free-run", errs);

    errs = timeouts + i_dut.i_assert.fail_cnt;
    hdr_cnt = 0;
    run_fill(12'h5b8, 3);  // dummy counter zeroed at each trigger
    report("fill two, dummy reset mode", errs);

    errs = timeouts + i_dut.i_assert.fail_cnt;
    hdr_cnt = 0;
    for (int t = 0; t < 4; t++) begin
      pulse_trigger();
      tick(30);
    end
    // short fill without triggers, a stored trigger would pop here
    @(posedge adc_clk) ext_enable <= 1'b1;
    tick(40);
    @(posedge adc_clk) ext_enable <= 1'b0;
    wait_done(2000);
    report("triggers while disabled", errs);

    errs = timeouts + i_dut.i_assert.fail_cnt;
    $display("tests run %0d, assertion failures %0d, timeouts %0d",
             tests_run, i_dut.i_assert.fail_cnt, timeouts);
    if (errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #2ms;
    $display("timeout: simulation ran past its time limit");
    $display("Errors found");
    $finish;
  end

endmodule

// File: sim/adc_acq_assert.sv
`timescale 1ns/1ps

module adc_acq_assert
  import acq_types_pkg::*;
  import acq_ctrl_pkg::*;
(
  input logic        adc_clk,
  input logic        arst_n,
  input logic        ext_enable,
  input logic        ext_trig,
  input acq_cfg_t    cfg,
  input logic [23:0] initial_fill_num,
  input logic        initial_fill_num_wr,
  input acq_word_t   out_word,
  input logic        out_valid,
  input logic [23:0] fill_num,
  input logic [15:0] waveform_num,
  input logic        acq_idle,
  input logic        ext_done
);

  int                   fail_cnt = 0;
  logic                 hdr_v;
  logic                 dat_v;
  logic                 trl_v;
  hdr_payload_t         hdr_f;
  logic [23:0]          exp_fill;   // fill number expected in the next header
  logic [15:0]          exp_wf;
  logic [7:0]           pend;       // trigger edges seen with the fill open
  logic                 trig_q;
  logic                 en_q;
  logic                 trail_q;
  logic                 in_wave;
  int                   dcnt;       // data words of the current waveform
  logic [11:0]          last_dat;
  logic [PAYLOAD_W-1:0] chk_ref;
  logic                 seq_ok;
  logic                 zero_ok;
  logic                 ovr_ok;
  logic                 dummy;
  logic                 rst_mode;

  assign hdr_v    = out_valid && out_word.tag == TAG_HDR;
  assign dat_v    = out_valid && out_word.tag == TAG_DATA;
  assign trl_v    = out_valid && out_word.tag == TAG_TRAIL;
  assign hdr_f    = out_word.payload;
  assign dummy    = cfg.channel_tag[3];
  assign rst_mode = cfg.channel_tag[4];

  // sample checks across one data word, first sample in the top field
  always_comb begin
    sample_t     cur;
    logic [11:0] prev;
    logic        have_prev;
    int          idx;
    seq_ok    = 1'b1;
    zero_ok   = 1'b1;
    ovr_ok    = 1'b1;
    prev      = last_dat;
    have_prev = (dcnt != 0);
    for (int k = 0; k < 4; k++) begin
      cur = out_word.payload[(3-k)*13 +: 13];
      idx = dcnt * 4 + k;
      if (cur.ovr) ovr_ok = 1'b0;
      if (rst_mode && idx == int'(cfg.pre_trig)) begin
        if (cur.dat != 12'd0) zero_ok = 1'b0;  // trigger point restarts at zero
      end else if (have_prev && cur.dat != 12'(prev + 12'd1)) begin
        seq_ok = 1'b0;
      end
      prev      = cur.dat;
      have_prev = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model of the word stream
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_fill <= '0;
      exp_wf   <= '0;
      pend     <= '0;
      trig_q   <= 1'b0;
      en_q     <= 1'b0;
      trail_q  <= 1'b0;
      in_wave  <= 1'b0;
      dcnt     <= 0;
      last_dat <= '0;
      chk_ref  <= '0;
    end else begin
      trig_q  <= ext_trig;
      en_q    <= ext_enable;
      trail_q <= trl_v;
      if (initial_fill_num_wr) exp_fill <= initial_fill_num;
      else if (ext_done) exp_fill <= exp_fill + 24'd1;
      pend <= pend + 8'(ext_trig & ~trig_q & (ext_enable | en_q)) - 8'(hdr_v);
      if (hdr_v) begin
        in_wave <= 1'b1;
        dcnt    <= 0;
        exp_wf  <= exp_wf + 16'd1;
      end else if (dat_v) begin
        dcnt     <= dcnt + 1;
        last_dat <= out_word.payload[11:0];  // last sample sits lowest
        chk_ref  <= chk_ref ^ out_word.payload;
      end else if (trl_v) begin
        in_wave <= 1'b0;
        exp_wf  <= '0;
        chk_ref <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge adc_clk)
      !arst_n |-> (!out_valid && !ext_done && acq_idle))
    else begin
      $error("error at %0t: outputs not idle in reset", $time);
      fail_cnt++;
    end
  a_hdr_fill: assert property (@(posedge adc_clk) disable iff (!arst_n)
      hdr_v |-> hdr_f.fill_num == exp_fill)
    else begin
      $error("error at %0t: header fill number wrong", $time);
      fail_cnt++;
    end
  a_hdr_wf: assert property (@(posedge adc_clk) disable iff (!arst_n)
      hdr_v |-> hdr_f.waveform_num == exp_wf)
    else begin
      $error("error at %0t: header waveform number wrong", $time);
      fail_cnt++;
    end
  a_hdr_tag: assert property (@(posedge adc_clk) disable iff (!arst_n)
      hdr_v |-> hdr_f.channel_tag == cfg.channel_tag)
    else begin
      $error("error at %0t: header channel tag wrong", $time);
      fail_cnt++;
    end
  a_hdr_trig: assert property (@(posedge adc_clk) disable iff (!arst_n) hdr_v |-> pend != 0)
    else begin
      $error("error at %0t: header without an enabled trigger", $time);
      fail_cnt++;
    end
  a_fill_out: assert property (@(posedge adc_clk) disable iff (!arst_n)
      fill_num == exp_fill)
    else begin
      $error("error at %0t: fill_num output wrong", $time);
      fail_cnt++;
    end
  a_wf_out: assert property (@(posedge adc_clk) disable iff (!arst_n)
      trl_v |-> waveform_num == exp_wf)
    else begin
      $error("error at %0t: waveform_num output wrong at trailer", $time);
      fail_cnt++;
    end
  a_words_end: assert property (@(posedge adc_clk) disable iff (!arst_n)
      ((hdr_v || trl_v) && in_wave) |-> dcnt == int'(cfg.num_words))
    else begin
      $error("error at %0t: waveform data word count wrong", $time);
      fail_cnt++;
    end
  a_words_max: assert property (@(posedge adc_clk) disable iff (!arst_n)
      dat_v |-> (in_wave && dcnt < int'(cfg.num_words)))
    else begin
      $error("error at %0t: unexpected data word", $time);
      fail_cnt++;
    end
  a_dummy_free: assert property (@(posedge adc_clk) disable iff (!arst_n)
      (dat_v && dummy && !rst_mode) |-> (seq_ok && ovr_ok))
    else begin
      $error("error at %0t: free-run dummy samples wrong", $time);
      fail_cnt++;
    end
  a_dummy_rst: assert property (@(posedge adc_clk) disable iff (!arst_n)
      (dat_v && dummy && rst_mode) |-> (seq_ok && zero_ok && ovr_ok))
    else begin
      $error("error at %0t: reset-mode dummy samples wrong", $time);
      fail_cnt++;
    end
  a_checksum: assert property (@(posedge adc_clk) disable iff (!arst_n)
      trl_v |-> out_word.payload == chk_ref)
    else begin
      $error("error at %0t: trailer checksum wrong", $time);
      fail_cnt++;
    end
  a_done_next: assert property (@(posedge adc_clk) disable iff (!arst_n) trl_v |=> ext_done)
    else begin
      $error("error at %0t: ext_done missing after trailer", $time);
      fail_cnt++;
    end
  a_done_src: assert property (@(posedge adc_clk) disable iff (!arst_n)
      ext_done |-> (trail_q && acq_idle))
    else begin
      $error("error at %0t: ext_done out of place", $time);
      fail_cnt++;
    end
  a_done_one: assert property (@(posedge adc_clk) disable iff (!arst_n) ext_done |=> !ext_done)
    else begin
      $error("error at %0t: ext_done longer than one cycle", $time);
      fail_cnt++;
    end

endmodule

bind adc_acq_top adc_acq_assert i_assert (
  .adc_clk             (adc_clk),
  .arst_n              (arst_n),
  .ext_enable          (ext_enable),
  .ext_trig            (ext_trig),
  .cfg                 (cfg),
  .initial_fill_num    (initial_fill_num),
  .initial_fill_num_wr (initial_fill_num_wr),
  .out_word            (out_word),
  .out_valid           (out_valid),
  .fill_num            (fill_num),
  .waveform_num        (waveform_num),
  .acq_idle            (acq_idle),
  .ext_done            (ext_done)
);

// File: logic/adc_acq_top.sv
`timescale 1ns/1ps
`include "adc_acq_macros.svh"

module adc_acq_top
  import acq_types_pkg::*;
  import acq_ctrl_pkg::*;
(
  input  logic        adc_clk,
  input  logic        arst_n,
  input  sample_t     adc_sample,
  input  logic        ext_enable,
  input  logic        ext_trig,
  input  acq_cfg_t    cfg,                  // stable during a fill
  input  logic [23:0] initial_fill_num,
  input  logic        initial_fill_num_wr,
  output acq_word_t   out_word,
  output logic        out_valid,
  output logic [23:0] fill_num,
  output logic [15:0] waveform_num,
  output logic        acq_idle,
  output logic        ext_done
);

  logic                cbuf_wr_en;
  logic                trig_pulse;
  logic                rd_en;
  logic                trail_req;
  logic                fill_start;
  logic                readout_idle;
  logic                trail_sent;
  logic [`CBUF_AW-1:0] wr_addr;
  sample_t             wr_sample;
  logic [`CBUF_AW-1:0] rd_addr;
  sample_t             rd_sample;
  logic                fifo_pop;
  logic                fifo_empty;
  logic                fifo_full;
  logic [`CBUF_AW-1:0] trig_addr;
  logic                timer_start;
  logic [`CBUF_AW-1:0] timer_base;
  logic                sample_strobe;
  logic                word_last;
  logic                timer_busy;

  ////////////////////////////////////////////////////////////
  // fill control and sample capture
  ////////////////////////////////////////////////////////////

  acq_enable_fsm i_enable_fsm (
    .adc_clk             (adc_clk),
    .arst_n              (arst_n),
    .ext_enable          (ext_enable),
    .ext_trig            (ext_trig),
    .fifo_full           (fifo_full),
    .readout_idle        (readout_idle),
    .trail_sent          (trail_sent),
    .initial_fill_num    (initial_fill_num),
    .initial_fill_num_wr (initial_fill_num_wr),
    .cbuf_wr_en          (cbuf_wr_en),
    .trig_pulse          (trig_pulse),
    .rd_en               (rd_en),
    .trail_req           (trail_req),
    .fill_start          (fill_start),
    .acq_idle            (acq_idle),
    .ext_done            (ext_done),
    .fill_num            (fill_num)
  );

  sample_source i_sample_source (
    .adc_clk    (adc_clk),
    .arst_n     (arst_n),
    .adc_sample (adc_sample),
    .cfg_tag    (cfg.channel_tag),
    .cbuf_wr_en (cbuf_wr_en),
    .trig_pulse (trig_pulse),
    .wr_addr    (wr_addr),
    .wr_sample  (wr_sample)
  );

  ////////////////////////////////////////////////////////////
  // buffer and trigger fifo
  ////////////////////////////////////////////////////////////

  circ_buf_ram i_circ_buf_ram (
    .adc_clk   (adc_clk),
    .we        (cbuf_wr_en),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .wr_sample (wr_sample),
    .rd_sample (rd_sample)
  );

  trig_addr_fifo i_trig_addr_fifo (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .push      (trig_pulse),
    .pop       (fifo_pop),
    .push_addr (wr_addr),    // address being written at the trigger
    .pop_addr  (trig_addr),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  ////////////////////////////////////////////////////////////
  // readout
  ////////////////////////////////////////////////////////////

  readout_timer i_readout_timer (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .start         (timer_start),
    .base_addr     (timer_base),
    .num_words     (cfg.num_words),
    .rd_addr       (rd_addr),
    .sample_strobe (sample_strobe),
    .word_last     (word_last),
    .busy          (timer_busy)
  );

  waveform_readout i_waveform_readout (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .rd_en         (rd_en),
    .trail_req     (trail_req),
    .fill_start    (fill_start),
    .cfg           (cfg),
    .fill_num      (fill_num),
    .fifo_empty    (fifo_empty),
    .trig_addr     (trig_addr),
    .rd_sample     (rd_sample),
    .pop           (fifo_pop),
    .timer_start   (timer_start),
    .timer_base    (timer_base),
    .sample_strobe (sample_strobe),
    .word_last     (word_last),
    .timer_busy    (timer_busy),
    .out_word      (out_word),
    .out_valid     (out_valid),
    .waveform_num  (waveform_num),
    .readout_idle  (readout_idle),
    .trail_sent    (trail_sent)
  );

endmodule

// File: readout/waveform_readout.sv
`timescale 1ns/1ps
`include "adc_acq_macros.svh"

module waveform_readout
  import acq_types_pkg::*;
  import acq_ctrl_pkg::*;
(
  input  logic                adc_clk,
  input  logic                arst_n,
  input  logic                rd_en,          // fill open or draining
  input  logic                trail_req,
  input  logic                fill_start,
  input  acq_cfg_t            cfg,
  input  logic [23:0]         fill_num,
  input  logic                fifo_empty,
  input  logic [`CBUF_AW-1:0] trig_addr,      // head of the trigger fifo
  input  sample_t             rd_sample,
  output logic                pop,
  output logic                timer_start,
  output logic [`CBUF_AW-1:0] timer_base,
  input  logic                sample_strobe,
  input  logic                word_last,
  input  logic                timer_busy,
  output acq_word_t           out_word,
  output logic                out_valid,
  output logic [15:0]         waveform_num,
  output logic                readout_idle,
  output logic                trail_sent
);

  typedef enum logic {
    RD_IDLE,  // waiting for a trigger address
    RD_RUN    // timer streaming samples
  } rd_state_e;

  rd_state_e            rd_state;
  data_payload_t        word_sr;    // samples of the word being built
  data_payload_t        word_nxt;
  logic [PAYLOAD_W-1:0] checksum;   // xor of data payloads in this fill
  hdr_payload_t         hdr;

  ////////////////////////////////////////////////////////////
  // trigger pop and timer start
  ////////////////////////////////////////////////////////////

  assign pop          = (rd_state == RD_IDLE) & rd_en & ~fifo_empty;
  assign timer_start  = pop;
  assign timer_base   = trig_addr - cfg.pre_trig[`CBUF_AW-1:0];  // wraps below zero
  assign readout_idle = (rd_state == RD_IDLE) & fifo_empty;

  assign hdr      = '{fill_num: fill_num, waveform_num: waveform_num,
                      channel_tag: cfg.channel_tag};
  assign word_nxt = {word_sr[`SAMPLES_PER_WORD-2:0], rd_sample};  // oldest moves up

  always_ff @(posedge adc_clk) begin
    if (sample_strobe) word_sr <= word_nxt;
    if (pop) begin
      out_word <= '{tag: TAG_HDR, payload: hdr};
    end else if (sample_strobe && word_last) begin
      out_word <= '{tag: TAG_DATA, payload: word_nxt};
    end else if (trail_req) begin
      out_word <= '{tag: TAG_TRAIL, payload: checksum};
    end
  end

  ////////////////////////////////////////////////////////////
  // control, counters and checksum
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state     <= RD_IDLE;
      out_valid    <= 1'b0;
      trail_sent   <= 1'b0;
      waveform_num <= '0;
      checksum     <= '0;
    end else begin
      out_valid  <= pop | (sample_strobe & word_last) | trail_req;
      trail_sent <= trail_req;
      case (rd_state)
        RD_IDLE: if (pop) rd_state <= RD_RUN;
        RD_RUN:  if (!timer_busy) rd_state <= RD_IDLE;  // last word already out
        default: rd_state <= RD_IDLE;
      endcase
      if (fill_start) begin
        waveform_num <= '0;
        checksum     <= '0;
      end else begin
        if (pop) waveform_num <= waveform_num + 16'd1;  // header took the old value
        if (sample_strobe && word_last) checksum <= checksum ^ word_nxt;
      end
    end
  end

endmodule

// File: readout/readout_timer.sv
`timescale 1ns/1ps
`include "adc_acq_macros.svh"

module readout_timer (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  logic                start,          // begin a waveform
  input  logic [`CBUF_AW-1:0] base_addr,      // first pre-trigger sample
  input  logic [9:0]          num_words,
  output logic [`CBUF_AW-1:0] rd_addr,
  output logic                sample_strobe,  // rd_sample valid this cycle
  output logic                word_last,      // with the strobe that closes a word
  output logic                busy            // reads issued or data still due
);

  localparam int SPW_W = $clog2(`SAMPLES_PER_WORD);

  logic             issuing;   // rd_addr is a live read this cycle
  logic [SPW_W-1:0] samp_cnt;  // sample within the word
  logic [9:0]       word_cnt;  // word within the waveform
  logic             samp_end;

  assign samp_end = (samp_cnt == SPW_W'(`SAMPLES_PER_WORD - 1));

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      issuing       <= 1'b0;
      rd_addr       <= '0;
      samp_cnt      <= '0;
      word_cnt      <= '0;
      sample_strobe <= 1'b0;
      word_last     <= 1'b0;
    end else begin
      sample_strobe <= issuing;             // ram read latency of one
      word_last     <= issuing & samp_end;
      if (start) begin
        issuing  <= 1'b1;
        rd_addr  <= base_addr;
        samp_cnt <= '0;
        word_cnt <= '0;
      end else if (issuing) begin
        rd_addr  <= rd_addr + 1'b1;         // wraps at the buffer size
        samp_cnt <= samp_cnt + 1'b1;
        if (samp_end) begin
          if (word_cnt == num_words - 10'd1) issuing <= 1'b0;  // last word read
          else word_cnt <= word_cnt + 10'd1;
        end
      end
    end
  end

  assign busy = issuing | sample_strobe;

endmodule

// File: circ_buf/trig_addr_fifo.sv
`timescale 1ns/1ps
`include "adc_acq_macros.svh"

module trig_addr_fifo (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  logic                push,       // never pushed when full
  input  logic                pop,        // never popped when empty
  input  logic [`CBUF_AW-1:0] push_addr,
  output logic [`CBUF_AW-1:0] pop_addr,   // head entry, shown ahead of pop
  output logic                empty,
  output logic                full
);

  logic [`CBUF_AW-1:0] mem [`FIFO_DEPTH];
  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`FIFO_AW:0]   count;   // one extra bit to tell full from empty

  always_ff @(posedge adc_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_addr;
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
    end
  end

  assign pop_addr = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == (`FIFO_AW+1)'(`FIFO_DEPTH));

endmodule

// File: circ_buf/circ_buf_ram.sv
`timescale 1ns/1ps
`include "adc_acq_macros.svh"

module circ_buf_ram
  import acq_types_pkg::*;
(
  input  logic                adc_clk,
  input  logic                we,
  input  logic [`CBUF_AW-1:0] wr_addr,
  input  logic [`CBUF_AW-1:0] rd_addr,
  input  sample_t             wr_sample,
  output sample_t             rd_sample   // valid one cycle after rd_addr
);

  sample_t mem [`CBUF_DEPTH];

  always_ff @(posedge adc_clk) begin
    if (we) begin
      mem[wr_addr] <= wr_sample;
    end
    rd_sample <= mem[rd_addr];  // registered read port
  end

endmodule

// File: logic/sample_source.sv
`timescale 1ns/1ps
`include "adc_acq_macros.svh"

module sample_source
  import acq_types_pkg::*;
(
  input  logic                adc_clk,
  input  logic                arst_n,
  input  sample_t             adc_sample,  // already registered at the pins
  input  logic [11:0]         cfg_tag,     // channel tag, mode bits 3 and 4
  input  logic                cbuf_wr_en,
  input  logic                trig_pulse,
  output logic [`CBUF_AW-1:0] wr_addr,
  output sample_t             wr_sample
);

  sample_t               adc_q;         // adc sample pipeline stage
  logic                  use_dummy;     // counter instead of adc
  logic                  dummy_rst_md;  // counter restarts at each trigger
  logic [`SAMPLE_W-2:0]  dummy_cnt;     // same width as the data field
  logic [`SAMPLE_W-2:0]  dummy_now;

  always_ff @(posedge adc_clk) begin
    adc_q <= adc_sample;
  end

  // zero lands exactly on the trigger address
  assign dummy_now = (dummy_rst_md & trig_pulse) ? '0 : dummy_cnt;
  assign wr_sample = use_dummy ? sample_t'{ovr: 1'b0, dat: dummy_now} : adc_q;

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      use_dummy    <= 1'b0;
      dummy_rst_md <= 1'b0;
      wr_addr      <= '0;
      dummy_cnt    <= '0;
    end else begin
      use_dummy    <= cfg_tag[3];
      dummy_rst_md <= cfg_tag[4];
      if (cbuf_wr_en) begin
        wr_addr   <= wr_addr + 1'b1;  // wraps around the buffer
        dummy_cnt <= dummy_now + 1'b1;
      end
    end
  end

endmodule

// File: logic/acq_enable_fsm.sv
`timescale 1ns/1ps

module acq_enable_fsm
  import acq_ctrl_pkg::*;
(
  input  logic        adc_clk,
  input  logic        arst_n,
  input  logic        ext_enable,          // fill window level
  input  logic        ext_trig,            // rising edge starts a waveform
  input  logic        fifo_full,           // trigger fifo has no room
  input  logic        readout_idle,        // no waveform pending or in flight
  input  logic        trail_sent,          // trailer word went out
  input  logic [23:0] initial_fill_num,
  input  logic        initial_fill_num_wr,
  output logic        cbuf_wr_en,          // circular buffer write enable
  output logic        trig_pulse,          // accepted trigger, one cycle
  output logic        rd_en,               // readout may pop triggers
  output logic        trail_req,           // send the trailer
  output logic        fill_start,          // first cycle of a fill
  output logic        acq_idle,
  output logic        ext_done,
  output logic [23:0] fill_num
);

  acq_state_e state;
  acq_state_e state_nxt;
  logic       trig_q;       // ext_trig one cycle back
  logic       trig_edge;
  logic       drain_done;

  assign trig_edge  = ext_trig & ~trig_q;
  // a pulse still in flight has not reached the fifo yet
  assign drain_done = readout_idle & ~trig_pulse;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (ext_enable) state_nxt = ST_ARMED;
      ST_ARMED: if (!ext_enable) state_nxt = ST_DRAIN;
      ST_DRAIN: if (drain_done) state_nxt = ST_TRAIL;
      ST_TRAIL: if (trail_sent) state_nxt = ST_DONE;
      ST_DONE:  state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      trig_q     <= 1'b0;
      trig_pulse <= 1'b0;
      fill_start <= 1'b0;
      trail_req  <= 1'b0;
      fill_num   <= '0;
    end else begin
      state      <= state_nxt;
      trig_q     <= ext_trig;
      trig_pulse <= (state == ST_ARMED) & trig_edge & ~fifo_full;  // full fifo drops it
      fill_start <= (state == ST_IDLE) & ext_enable;
      trail_req  <= (state == ST_DRAIN) & drain_done;
      if (initial_fill_num_wr) begin
        fill_num <= initial_fill_num;  // load wins over the increment
      end else if (state == ST_DONE) begin
        fill_num <= fill_num + 24'd1;
      end
    end
  end

  // decoded from the state register
  assign cbuf_wr_en = (state == ST_ARMED) | (state == ST_DRAIN);  // keeps post-trigger data
  assign rd_en      = (state == ST_ARMED) | (state == ST_DRAIN);
  assign ext_done   = (state == ST_DONE);
  assign acq_idle   = (state == ST_IDLE) | (state == ST_DONE);   // rises with ext_done

endmodule

// File: common/acq_ctrl_pkg.sv
package acq_ctrl_pkg;

  // fill sequence of the enable fsm
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,  // waiting for enable
    ST_ARMED = 3'd1,  // writing buffer, triggers accepted
    ST_DRAIN = 3'd2,  // enable gone, readout finishing
    ST_TRAIL = 3'd3,  // checksum word going out
    ST_DONE  = 3'd4   // one cycle done pulse
  } acq_state_e;

  typedef struct packed {
    logic [11:0] channel_tag;  // bit 3 dummy data, bit 4 dummy reset per trigger
    logic [9:0]  num_words;    // data words per waveform, at least 1
    logic [11:0] pre_trig;     // samples before the trigger point
  } acq_cfg_t;

endpackage

// File: common/acq_types_pkg.sv
package acq_types_pkg;

  `include "adc_acq_macros.svh"

  localparam int PAYLOAD_W = `SAMPLES_PER_WORD * `SAMPLE_W; // 52 bits

  typedef struct packed {
    logic        ovr;  // adc over-range flag
    logic [11:0] dat;  // adc value
  } sample_t;

  typedef enum logic [3:0] {
    TAG_HDR   = 4'h1,  // waveform header
    TAG_DATA  = 4'h2,  // four samples
    TAG_TRAIL = 4'h3   // fill checksum
  } word_tag_e;

  typedef struct packed {
    logic [23:0] fill_num;
    logic [15:0] waveform_num;
    logic [11:0] channel_tag;
  } hdr_payload_t;

  // first sample of the word sits in the highest field
  typedef sample_t [`SAMPLES_PER_WORD-1:0] data_payload_t;

  typedef struct packed {
    word_tag_e              tag;
    logic [PAYLOAD_W-1:0]   payload;
  } acq_word_t;

endpackage

// File: common/adc_acq_macros.svh
`ifndef ADC_ACQ_MACROS_SVH
`define ADC_ACQ_MACROS_SVH

////////////////////////////////////////////////////////////
// buffer and data sizes
////////////////////////////////////////////////////////////

// circular sample buffer, 4096 samples
`define CBUF_AW 12
`define CBUF_DEPTH (1 << `CBUF_AW)

// trigger address fifo, 16 entries
`define FIFO_AW 4
`define FIFO_DEPTH (1 << `FIFO_AW)

`define SAMPLE_W 13          // over-range bit plus 12-bit adc value
`define SAMPLES_PER_WORD 4   // samples packed in one data word

`endif
